/* logic/icache_macros.svh */
// Sizing macros for the instruction cache
// Program counter, line, cache, fetch and warp dimensions

`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Program counter width in bits
`define ICACHE_PC_WIDTH 8

// Slot bits within a line, four instructions per line
`define ICACHE_LINE_IDX_BITS 2

// Number of lines in the cache
`define ICACHE_NUM_LINES 8

// Instructions returned per fetch, at most one line
`define ICACHE_FETCH_WIDTH 4

// Encoded instruction width
`define ICACHE_INST_WIDTH 4

`define ICACHE_NUM_WARPS 8

`endif

/* logic/icache_pkg.sv */
// Width types and controller state encoding for the instruction cache

`include "icache_macros.svh"

package icache_pkg;

    // PC = {tag, line select, slot}
    typedef logic [`ICACHE_PC_WIDTH-1:0]           pc_t;
    typedef logic [`ICACHE_LINE_IDX_BITS-1:0]      line_off_t;
    typedef logic [$clog2(`ICACHE_NUM_LINES)-1:0]  line_sel_t;
    typedef logic [`ICACHE_PC_WIDTH-`ICACHE_LINE_IDX_BITS
                   -$clog2(`ICACHE_NUM_LINES)-1:0] tag_t;

    // Memory line address, the PC without its slot bits
    typedef logic [`ICACHE_PC_WIDTH-`ICACHE_LINE_IDX_BITS-1:0] line_addr_t;

    typedef logic [`ICACHE_INST_WIDTH-1:0] enc_inst_t;
    typedef logic [(`ICACHE_INST_WIDTH << `ICACHE_LINE_IDX_BITS)-1:0] line_data_t;

    typedef logic [`ICACHE_FETCH_WIDTH-1:0]       fetch_mask_t;
    typedef logic [$clog2(`ICACHE_NUM_WARPS)-1:0] wid_t;

    // Request controller states
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOOKUP   = 2'd1,
        WAIT_MEM = 2'd2,
        WAIT_DEC = 2'd3
    } icache_state_e;

endpackage

/* logic/icache_line_if.sv */
// Controller to line store path: lookup, refill write and invalidate

`timescale 1ns/1ps

interface icache_line_if;
    import icache_pkg::*;

    // Request side, driven by the controller
    logic       lookup_req;
    logic       write_en;
    line_sel_t  line_sel;
    tag_t       write_tag;
    line_data_t write_data;
    logic       clear_all;

    // Registered lookup result, one cycle after lookup_req
    logic       read_valid;
    tag_t       read_tag;
    line_data_t read_data;

    modport ctrl (
        output lookup_req, write_en, line_sel, write_tag, write_data, clear_all,
        input  read_valid, read_tag, read_data
    );

    modport store (
        input  lookup_req, write_en, line_sel, write_tag, write_data, clear_all,
        output read_valid, read_tag, read_data
    );

endinterface

/* logic/icache_line_store.sv */
// Tag array, instruction array and valid bits of the instruction cache
// Synchronous read with one cycle latency, write on the sampling edge

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_line_store (
    input logic          clk_i,
    input logic          rst_ni,
    icache_line_if.store line_if
);
    import icache_pkg::*;

    // ################################################
    // Storage
    // ################################################

    tag_t                         tag_mem  [`ICACHE_NUM_LINES];
    line_data_t                   data_mem [`ICACHE_NUM_LINES];
    logic [`ICACHE_NUM_LINES-1:0] valid_q;

    // Valid bits, cleared all at once on a flush
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (line_if.clear_all) begin
            valid_q <= '0;
        end else if (line_if.write_en) begin
            valid_q[line_if.line_sel] <= 1'b1;
        end
    end

    // Refill write of tag and line
    always_ff @(posedge clk_i) begin
        if (line_if.write_en) begin
            tag_mem[line_if.line_sel]  <= line_if.write_tag;
            data_mem[line_if.line_sel] <= line_if.write_data;
        end
    end

    // ################################################
    // Lookup read port
    // ################################################

    // Valid bit of the looked up line
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            line_if.read_valid <= 1'b0;
        end else if (line_if.lookup_req) begin
            line_if.read_valid <= valid_q[line_if.line_sel];
        end
    end

    // Tag and data held until the next lookup
    always_ff @(posedge clk_i) begin
        if (line_if.lookup_req) begin
            line_if.read_tag  <= tag_mem[line_if.line_sel];
            line_if.read_data <= data_mem[line_if.line_sel];
        end
    end

endmodule

/* logic/icache_ctrl.sv */
// Request FSM of the instruction cache
// Active request register, hit check, refill buffer and pending flush

`timescale 1ns/1ps

module icache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     flush_i,
    // Fetcher
    input  logic                     fe_valid_i,
    output logic                     ic_ready_o,
    input  icache_pkg::pc_t          fe_pc_i,
    input  icache_pkg::fetch_mask_t  fe_fetch_mask_i,
    input  icache_pkg::wid_t         fe_warp_id_i,
    // Memory
    output logic                     mem_req_o,
    input  logic                     mem_ready_i,
    output icache_pkg::line_addr_t   mem_addr_o,
    input  logic                     mem_valid_i,
    input  icache_pkg::line_data_t   mem_data_i,
    // Decoder side, sliced by the aligner
    input  logic                     dec_ready_i,
    output logic                     out_present_o,
    output icache_pkg::line_data_t   out_line_o,
    output icache_pkg::pc_t          out_pc_o,
    output icache_pkg::fetch_mask_t  out_fetch_mask_o,
    output icache_pkg::wid_t         out_warp_id_o,
    // Line store
    icache_line_if.ctrl              line_if
);
    import icache_pkg::*;

    icache_state_e state_q, state_d;
    logic          flush_q;

    // Active request
    pc_t         active_pc_q;
    fetch_mask_t active_mask_q;
    wid_t        active_wid_q;
    line_data_t  refill_q;

    logic hit;
    logic slot_free;
    logic flush_take;
    logic fe_accept;

    // ################################################
    // Hit check and handshakes
    // ################################################

    assign hit = line_if.read_valid
              && (line_if.read_tag == tag_t'(active_pc_q >> ($bits(line_off_t)
                                                            + $bits(line_sel_t))));

    assign out_present_o = ((state_q == LOOKUP) && hit) || (state_q == WAIT_DEC);

    // Free for a new request when idle or when the decoder takes the result
    assign slot_free  = (state_q == IDLE) || (out_present_o && dec_ready_i);
    // Pending flush wins over a new fetch
    assign flush_take = slot_free && flush_q;
    assign ic_ready_o = slot_free && !flush_q;
    assign fe_accept  = ic_ready_o && fe_valid_i;

    assign mem_req_o  = (state_q == LOOKUP) && !hit;
    assign mem_addr_o = mem_req_o ? line_addr_t'(active_pc_q >> $bits(line_off_t)) : '0;

    // Store requests
    assign line_if.lookup_req = fe_accept;
    assign line_if.write_en   = (state_q == WAIT_MEM) && mem_valid_i;
    assign line_if.line_sel   = fe_accept ? line_sel_t'(fe_pc_i >> $bits(line_off_t))
                                          : line_sel_t'(active_pc_q >> $bits(line_off_t));
    assign line_if.write_tag  = tag_t'(active_pc_q >> ($bits(line_off_t) + $bits(line_sel_t)));
    assign line_if.write_data = mem_data_i;
    assign line_if.clear_all  = flush_take;

    // ################################################
    // Next state
    // ################################################

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fe_accept) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (!hit) begin
                    if (mem_ready_i) begin
                        state_d = WAIT_MEM;
                    end
                end else if (dec_ready_i) begin
                    state_d = fe_accept ? LOOKUP : IDLE;
                end
            end
            WAIT_MEM: begin
                if (mem_valid_i) begin
                    state_d = WAIT_DEC;
                end
            end
            WAIT_DEC: begin
                if (dec_ready_i) begin
                    state_d = fe_accept ? LOOKUP : IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            flush_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // A flush arriving while one is consumed stays pending
            flush_q <= flush_i || (flush_q && !flush_take);
        end
    end

    // Request payload and refill line
    always_ff @(posedge clk_i) begin
        if (fe_accept) begin
            active_pc_q   <= fe_pc_i;
            active_mask_q <= fe_fetch_mask_i;
            active_wid_q  <= fe_warp_id_i;
        end
        if (line_if.write_en) begin
            refill_q <= mem_data_i;
        end
    end

    // ################################################
    // Outputs towards the decoder
    // ################################################

    // After a miss the line comes from the refill buffer
    assign out_line_o       = (state_q == WAIT_DEC) ? refill_q : line_if.read_data;
    assign out_pc_o         = out_present_o ? active_pc_q   : '0;
    assign out_fetch_mask_o = out_present_o ? active_mask_q : '0;
    assign out_warp_id_o    = out_present_o ? active_wid_q  : '0;

endmodule

/* logic/icache_fetch_align.sv */
// Fetch window slicing: instructions and per-slot valid mask
// Slots past the end of the line are cut off

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_fetch_align (
    input  logic                                               present_i,
    input  icache_pkg::line_data_t                             line_i,
    input  icache_pkg::pc_t                                    pc_i,
    input  icache_pkg::fetch_mask_t                            fetch_mask_i,
    output icache_pkg::enc_inst_t [`ICACHE_FETCH_WIDTH-1:0]    inst_o,
    output icache_pkg::fetch_mask_t                            valid_o
);
    import icache_pkg::*;

    localparam int unsigned LINE_INSTS = 1 << `ICACHE_LINE_IDX_BITS;

    line_off_t offset;

    // Slot of the first instruction
    assign offset = line_off_t'(pc_i);

    always_comb begin
        line_off_t slot;

        inst_o  = '0;
        valid_o = '0;
        for (int k = 0; k < `ICACHE_FETCH_WIDTH; k++) begin
            slot = line_off_t'(int'(offset) + k);
            // Window must stay inside the line
            if (present_i && fetch_mask_i[k] && ((int'(offset) + k) < LINE_INSTS)) begin
                valid_o[k] = 1'b1;
                inst_o[k]  = line_i[slot*$bits(enc_inst_t) +: $bits(enc_inst_t)];
            end
        end
    end

endmodule

/* logic/instruction_cache.sv */
// Direct-mapped instruction cache top level
// Controller, line store and fetch aligner behind plain ports

`timescale 1ns/1ps

`include "icache_macros.svh"

module instruction_cache (
    input  logic                                             clk_i,
    input  logic                                             rst_ni,
    input  logic                                             flush_i,
    // Memory request and response
    input  logic                                             mem_ready_i,
    output logic                                             mem_req_o,
    output icache_pkg::line_addr_t                           mem_addr_o,
    input  logic                                             mem_valid_i,
    input  icache_pkg::line_data_t                           mem_data_i,
    // Fetcher
    input  logic                                             fe_valid_i,
    output logic                                             ic_ready_o,
    input  icache_pkg::pc_t                                  fe_pc_i,
    input  icache_pkg::fetch_mask_t                          fe_fetch_mask_i,
    input  icache_pkg::wid_t                                 fe_warp_id_i,
    // Decoder
    input  logic                                             dec_ready_i,
    output icache_pkg::fetch_mask_t                          ic_valid_o,
    output icache_pkg::fetch_mask_t                          ic_fetch_mask_o,
    output icache_pkg::pc_t                                  ic_pc_o,
    output icache_pkg::wid_t                                 ic_warp_id_o,
    output icache_pkg::enc_inst_t [`ICACHE_FETCH_WIDTH-1:0]  ic_inst_o
);
    import icache_pkg::*;

    logic       out_present;
    line_data_t out_line;

    icache_line_if line_if ();

    icache_line_store u_line_store (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .line_if (line_if.store)
    );

    icache_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .flush_i          (flush_i),
        .fe_valid_i       (fe_valid_i),
        .ic_ready_o       (ic_ready_o),
        .fe_pc_i          (fe_pc_i),
        .fe_fetch_mask_i  (fe_fetch_mask_i),
        .fe_warp_id_i     (fe_warp_id_i),
        .mem_req_o        (mem_req_o),
        .mem_ready_i      (mem_ready_i),
        .mem_addr_o       (mem_addr_o),
        .mem_valid_i      (mem_valid_i),
        .mem_data_i       (mem_data_i),
        .dec_ready_i      (dec_ready_i),
        .out_present_o    (out_present),
        .out_line_o       (out_line),
        .out_pc_o         (ic_pc_o),
        .out_fetch_mask_o (ic_fetch_mask_o),
        .out_warp_id_o    (ic_warp_id_o),
        .line_if          (line_if.ctrl)
    );

    // Window slicing reads the same PC and mask the decoder sees
    icache_fetch_align u_fetch_align (
        .present_i    (out_present),
        .line_i       (out_line),
        .pc_i         (ic_pc_o),
        .fetch_mask_i (ic_fetch_mask_o),
        .inst_o       (ic_inst_o),
        .valid_o      (ic_valid_o)
    );

endmodule

/* dv/icache_checker.sv */
// Checker with reference slicing, shadow tags and output comparisons

`timescale 1ns/1ps

`include "icache_macros.svh"

module icache_checker (
    input  logic                                            clk_i,
    input  logic                                            rst_ni,
    input  logic                                            flush_i,
    input  logic                                            fe_valid_i,
    input  logic                                            ic_ready_i,
    input  icache_pkg::pc_t                                 fe_pc_i,
    input  icache_pkg::fetch_mask_t                         fe_fetch_mask_i,
    input  icache_pkg::wid_t                                fe_warp_id_i,
    input  logic                                            mem_req_i,
    input  logic                                            mem_ready_i,
    input  icache_pkg::line_addr_t                          mem_addr_i,
    input  logic                                            dec_ready_i,
    input  icache_pkg::fetch_mask_t                         ic_valid_i,
    input  icache_pkg::fetch_mask_t                         ic_fetch_mask_i,
    input  icache_pkg::pc_t                                 ic_pc_i,
    input  icache_pkg::wid_t                                ic_warp_id_i,
    input  icache_pkg::enc_inst_t [`ICACHE_FETCH_WIDTH-1:0] ic_inst_i,
    input  int                                              generation_i,
    output int                                              error_count_o,
    output int                                              check_count_o
);
    import icache_pkg::*;

    // Shadow of tag and valid per line
    logic [2:0] shadow_tag [8];
    logic [7:0] shadow_valid;

    // Accepted fetches awaiting their decoder transfer
    pc_t         pc_q   [$];
    fetch_mask_t mask_q [$];
    wid_t        wid_q  [$];
    logic        miss_q [$];
    logic        req_seen;

    // Previous cycle of the decoder outputs
    logic        stall_prev;
    fetch_mask_t prev_valid;
    fetch_mask_t prev_mask;
    pc_t         prev_pc;
    wid_t        prev_wid;
    logic [15:0] prev_inst;

    fetch_mask_t exp_valid;
    logic [15:0] exp_inst;
    logic [15:0] cur_inst;
    logic [2:0]  sel;

    // Slot s of line a holds a*4 + s + 3*generation
    function automatic void ref_fetch(input pc_t pc, input fetch_mask_t mask, input int gen,
                                      output fetch_mask_t valid, output logic [15:0] insts);
        int off;
        int la;
        int s;
        off   = int'(pc[1:0]);
        la    = int'(pc >> 2);
        valid = '0;
        insts = '0;
        for (int k = 0; k < `ICACHE_FETCH_WIDTH; k++) begin
            s = off + k;
            if (mask[k] && s < 4) begin
                valid[k]         = 1'b1;
                insts[k*4 +: 4] = 4'(la * 4 + s + 3 * gen);
            end
        end
    endfunction

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        check_count_o++;
        if (got !== exp) begin
            error_count_o++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    initial begin
        error_count_o = 0;
        check_count_o = 0;
    end

    always @(posedge clk_i) begin
        cur_inst = ic_inst_i;
        if (!rst_ni) begin
            shadow_valid = '0;
            stall_prev   = 1'b0;
            req_seen     = 1'b0;
        end else begin
            // ################################################
            // Back-pressure hold of the decoder outputs
            // ################################################
            if (stall_prev) begin
                compare("ic_valid_o held", 16'(ic_valid_i), 16'(prev_valid));
                compare("ic_fetch_mask_o held", 16'(ic_fetch_mask_i), 16'(prev_mask));
                compare("ic_pc_o held", 16'(ic_pc_i), 16'(prev_pc));
                compare("ic_warp_id_o held", 16'(ic_warp_id_i), 16'(prev_wid));
                compare("ic_inst_o held", cur_inst, prev_inst);
            end
            stall_prev = (|ic_valid_i) && !dec_ready_i;
            prev_valid = ic_valid_i;
            prev_mask  = ic_fetch_mask_i;
            prev_pc    = ic_pc_i;
            prev_wid   = ic_warp_id_i;
            prev_inst  = cur_inst;

            // Only one fetch in flight until the decoder takes its result
            if ((pc_q.size() != 0) && !((|ic_valid_i) && dec_ready_i)) begin
                compare("ic_ready_o", 16'(ic_ready_i), 16'h0000);
            end

            // Decoder transfer
            if ((|ic_valid_i) && dec_ready_i) begin
                if (pc_q.size() == 0) begin
                    error_count_o++;
                    $display("decoder transfer seen with no accepted fetch");
                end else begin
                    ref_fetch(pc_q[0], mask_q[0], generation_i, exp_valid, exp_inst);
                    compare("ic_valid_o", 16'(ic_valid_i), 16'(exp_valid));
                    compare("ic_inst_o", cur_inst, exp_inst);
                    compare("ic_pc_o", 16'(ic_pc_i), 16'(pc_q[0]));
                    compare("ic_fetch_mask_o", 16'(ic_fetch_mask_i), 16'(mask_q[0]));
                    compare("ic_warp_id_o", 16'(ic_warp_id_i), 16'(wid_q[0]));
                    if (miss_q[0] && !req_seen) begin
                        error_count_o++;
                        $display("fetch to a missing line finished without a memory request");
                    end
                    void'(pc_q.pop_front());
                    void'(mask_q.pop_front());
                    void'(wid_q.pop_front());
                    void'(miss_q.pop_front());
                    req_seen = 1'b0;
                end
            end

            // Taken memory request refills the shadow line
            if (mem_req_i && mem_ready_i) begin
                if (pc_q.size() == 0) begin
                    error_count_o++;
                    $display("memory request taken with no accepted fetch");
                end else begin
                    compare("mem_addr_o", 16'(mem_addr_i), 16'(pc_q[0] >> 2));
                    if (!miss_q[0]) begin
                        error_count_o++;
                        $display("memory request for a fetch whose line is resident");
                    end
                    req_seen               = 1'b1;
                    sel                    = pc_q[0][4:2];
                    shadow_valid[sel]      = 1'b1;
                    shadow_tag[sel]        = pc_q[0][7:5];
                end
            end

            // Accepted fetch with hit or miss taken from the shadow
            if (fe_valid_i && ic_ready_i) begin
                sel = fe_pc_i[4:2];
                pc_q.push_back(fe_pc_i);
                mask_q.push_back(fe_fetch_mask_i);
                wid_q.push_back(fe_warp_id_i);
                miss_q.push_back(!(shadow_valid[sel] && shadow_tag[sel] == fe_pc_i[7:5]));
            end

            if (flush_i) begin
                shadow_valid = '0;
            end
        end
    end

endmodule

/* dv/tb_instruction_cache.sv */
// Testbench with clock, reset, fetcher, decoder and memory model

`timescale 1ns/1ps

`include "icache_macros.svh"

module tb_instruction_cache;
    import icache_pkg::*;

    localparam int SEED    = 75678;
    localparam int TIMEOUT = 200;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        mem_ready_i;
    logic        mem_req_o;
    line_addr_t  mem_addr_o;
    logic        mem_valid_i;
    line_data_t  mem_data_i;
    logic        fe_valid_i;
    logic        ic_ready_o;
    pc_t         fe_pc_i;
    fetch_mask_t fe_fetch_mask_i;
    wid_t        fe_warp_id_i;
    logic        dec_ready_i;
    fetch_mask_t ic_valid_o;
    fetch_mask_t ic_fetch_mask_o;
    pc_t         ic_pc_o;
    wid_t        ic_warp_id_o;
    enc_inst_t [`ICACHE_FETCH_WIDTH-1:0] ic_inst_o;

    int   generation;
    int   error_count;
    int   check_count;
    logic timed_out;
    int   delay;
    line_addr_t  resp_addr;

    // PCs that revisit lines
    // 0x10 and 0x90 share line index 4
    pc_t pc_set [8] = '{8'h10, 8'h12, 8'h90, 8'h93, 8'h25, 8'h47, 8'hA5, 8'h11};

    instruction_cache u_instruction_cache (.*);

    icache_checker u_checker (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .flush_i         (flush_i),
        .fe_valid_i      (fe_valid_i),
        .ic_ready_i      (ic_ready_o),
        .fe_pc_i         (fe_pc_i),
        .fe_fetch_mask_i (fe_fetch_mask_i),
        .fe_warp_id_i    (fe_warp_id_i),
        .mem_req_i       (mem_req_o),
        .mem_ready_i     (mem_ready_i),
        .mem_addr_i      (mem_addr_o),
        .dec_ready_i     (dec_ready_i),
        .ic_valid_i      (ic_valid_o),
        .ic_fetch_mask_i (ic_fetch_mask_o),
        .ic_pc_i         (ic_pc_o),
        .ic_warp_id_i    (ic_warp_id_o),
        .ic_inst_i       (ic_inst_o),
        .generation_i    (generation),
        .error_count_o   (error_count),
        .check_count_o   (check_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Slot k of a memory line holds line address times four plus k plus 3 per generation
    function automatic line_data_t make_line(input line_addr_t addr, input int gen);
        line_data_t line;
        for (int k = 0; k < 4; k++) begin
            line[k*4 +: 4] = 4'(int'(addr) * 4 + k + 3 * gen);
        end
        return line;
    endfunction

    // ################################################
    // Memory model and decoder ready
    // ################################################

    initial begin
        forever begin
            @(posedge clk_i);
            if (rst_ni && mem_req_o && mem_ready_i) begin
                resp_addr = mem_addr_o;
                delay     = int'($urandom_range(4, 1));
                repeat (delay - 1) @(posedge clk_i);
                #2;
                mem_valid_i = 1'b1;
                mem_data_i  = make_line(resp_addr, generation);
                @(posedge clk_i);
                #2;
                mem_valid_i = 1'b0;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk_i);
            #2;
            if (rst_ni) begin
                mem_ready_i = ($urandom % 2) == 0;
                dec_ready_i = ($urandom % 4) != 0;
            end
        end
    end

    // ################################################
    // Fetcher tasks
    // ################################################

    task automatic fetch(input pc_t pc, input fetch_mask_t mask, input wid_t wid);
        int n;
        if (timed_out) return;
        @(posedge clk_i);
        #2;
        fe_valid_i      = 1'b1;
        fe_pc_i         = pc;
        fe_fetch_mask_i = mask;
        fe_warp_id_i    = wid;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!ic_ready_o && n < TIMEOUT);
        #2;
        fe_valid_i = 1'b0;
        if (n >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("timeout: fetch for pc %h was never accepted", pc);
            return;
        end
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!((|ic_valid_o) && dec_ready_i) && n < TIMEOUT);
        if (n >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("timeout: no decoder transfer for pc %h", pc);
        end
    endtask

    task automatic flush_cache();
        int n;
        if (timed_out) return;
        @(posedge clk_i);
        #2;
        flush_i    = 1'b1;
        generation = generation + 1;
        @(posedge clk_i);
        #2;
        flush_i = 1'b0;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
        end while (!ic_ready_o && n < TIMEOUT);
        if (n >= TIMEOUT) begin
            timed_out = 1'b1;
            $display("timeout: cache never became ready after a flush");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst_ni          = 1'b0;
        flush_i         = 1'b0;
        mem_ready_i     = 1'b0;
        mem_valid_i     = 1'b0;
        mem_data_i      = '0;
        fe_valid_i      = 1'b0;
        fe_pc_i         = '0;
        fe_fetch_mask_i = '0;
        fe_warp_id_i    = '0;
        dec_ready_i     = 1'b0;
        generation      = 0;
        timed_out       = 1'b0;
        repeat (16) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;

        // Miss, hit, window cut and partial mask
        fetch(8'h10, 4'hF, 3'd1);
        fetch(8'h10, 4'hF, 3'd2);
        fetch(8'h12, 4'hF, 3'd3);
        fetch(8'h12, 4'h1, 3'd4);
        // Conflict eviction on line index 4
        fetch(8'h90, 4'h7, 3'd5);
        fetch(8'h10, 4'h3, 3'd6);
        // Resident line misses after a flush
        flush_cache();
        fetch(8'h10, 4'hF, 3'd7);

        for (int i = 0; i < 150 && !timed_out; i++) begin
            if ($urandom % 16 == 0) begin
                flush_cache();
            end
            fetch(pc_set[$urandom % 8], fetch_mask_t'((1 << ($urandom_range(4, 1))) - 1),
                  wid_t'($urandom));
        end

        repeat (4) @(posedge clk_i);
        $display("errors %0d, timeouts %0d, checks %0d", error_count, int'(timed_out),
                 check_count);
        if (error_count == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* instruction_cache.f */
+incdir+logic
logic/icache_pkg.sv
logic/icache_line_if.sv
logic/icache_line_store.sv
logic/icache_ctrl.sv
logic/icache_fetch_align.sv
logic/instruction_cache.sv
dv/icache_checker.sv
dv/tb_instruction_cache.sv

/* run.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f instruction_cache.f --top-module tb_instruction_cache \
    -o sim_tb_instruction_cache

out=$(./obj_dir/sim_tb_instruction_cache)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
else
    exit 1
fi
